/* build.f */
+incdir+include
hdl/mem_stage_pkg.sv
hdl/ex_mem_reg.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/dmem_wb_master.sv
hdl/mem_stage_top.sv
verif/tb_dmem_model.sv
verif/tb_mem_stage.sv

/* hdl/dmem_wb_master.sv */
`include "mem_stage_settings.svh"

module dmem_wb_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,    // valid mem item while idle
    input  logic                     is_store,
    input  mem_stage_pkg::addr_t     addr,
    input  mem_stage_pkg::xdata_t    st_data,
    input  mem_stage_pkg::lane_sel_t st_sel,
    input  logic                     leave,    // item accepted downstream
    input  mem_stage_pkg::xdata_t    wb_dat_i,
    input  logic                     wb_ack,
    output logic                     mem_done,
    output mem_stage_pkg::xdata_t    rdata,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output mem_stage_pkg::addr_t     wb_adr,
    output mem_stage_pkg::lane_sel_t wb_sel,
    output mem_stage_pkg::xdata_t    wb_dat_o
);

    localparam int OFFW = $clog2(`MS_LANES);

    mem_stage_pkg::dmem_state_e state;

    assign mem_done = (state == mem_stage_pkg::DM_DONE);

    // ******************************
    // FSM and bus control
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= mem_stage_pkg::DM_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (state)
                mem_stage_pkg::DM_IDLE: begin
                    if (start) begin
                        state  <= mem_stage_pkg::DM_ACCESS;
                        wb_cyc <= 1'b1;   // cyc and stb rise together
                        wb_stb <= 1'b1;
                        wb_we  <= is_store;
                    end
                end
                mem_stage_pkg::DM_ACCESS: begin
                    if (wb_ack) begin
                        state  <= mem_stage_pkg::DM_DONE;
                        wb_cyc <= 1'b0;   // single beat, end of cycle
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                    end
                end
                mem_stage_pkg::DM_DONE: begin
                    if (leave) begin
                        state <= mem_stage_pkg::DM_IDLE;
                    end
                end
                default: state <= mem_stage_pkg::DM_IDLE;
            endcase
        end
    end

    // address, data and lanes frozen for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= {addr[`MS_ALEN-1:OFFW], {OFFW{1'b0}}}; // word aligned
            wb_dat_o <= st_data;
            wb_sel   <= st_sel;
        end
    end

    // read data held until the item leaves
    always_ff @(posedge clk) begin
        if (state == mem_stage_pkg::DM_ACCESS && wb_ack && !wb_we) begin
            rdata <= wb_dat_i;
        end
    end

    // ******************************
    // bus protocol checks
    // ******************************
    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_sel));

    // slave may only answer an open request
    assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> state == mem_stage_pkg::DM_ACCESS);

endmodule

/* hdl/ex_mem_reg.sv */
module ex_mem_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_en,    // stage can take an item this cycle
    input  logic                    hold_clear, // held item leaves downstream
    input  mem_stage_pkg::ex_mem_t  in_item,
    input  logic                    in_valid,
    output mem_stage_pkg::ex_mem_t  held_item,
    output logic                    held_valid
);

    logic capture;

    assign capture = load_en && in_valid; // upstream transfer

    // ******************************
    // valid flag
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (capture) begin
            held_valid <= 1'b1;           // refill, also covers leave + enter
        end else if (hold_clear) begin
            held_valid <= 1'b0;           // left with nothing behind it
        end
    end

    // payload, only valid tracks reset
    always_ff @(posedge clk) begin
        if (capture) begin
            held_item <= in_item;
        end
    end

endmodule

/* hdl/load_extract.sv */
`include "mem_stage_settings.svh"

module load_extract (
    input  mem_stage_pkg::mem_op_e mem_op,
    input  logic [2:0]             byte_off,
    input  mem_stage_pkg::xdata_t  rdata,
    output mem_stage_pkg::xdata_t  ld_value
);

    mem_stage_pkg::xdata_t shifted; // addressed byte now in lane 0

    assign shifted = rdata >> {byte_off, 3'b000};

    // ******************************
    // extension by op
    // ******************************
    always_comb begin
        case (mem_op)
            mem_stage_pkg::MEM_LB: begin
                ld_value = {{(`MS_XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            mem_stage_pkg::MEM_LH: begin
                ld_value = {{(`MS_XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            mem_stage_pkg::MEM_LW: begin
                ld_value = {{(`MS_XLEN-32){shifted[31]}}, shifted[31:0]};
            end
            mem_stage_pkg::MEM_LBU: begin
                ld_value = {{(`MS_XLEN-8){1'b0}}, shifted[7:0]};
            end
            mem_stage_pkg::MEM_LHU: begin
                ld_value = {{(`MS_XLEN-16){1'b0}}, shifted[15:0]};
            end
            mem_stage_pkg::MEM_LWU: begin
                ld_value = {{(`MS_XLEN-32){1'b0}}, shifted[31:0]};
            end
            mem_stage_pkg::MEM_LD: begin
                ld_value = rdata;         // no lane select for a double
            end
            default: begin
                ld_value = '0;            // stores and none, never selected
            end
        endcase
    end

endmodule

/* hdl/mem_stage_pkg.sv */
`include "mem_stage_settings.svh"

package mem_stage_pkg;

    // ******************************
    // plain vector types
    // ******************************
    typedef logic [`MS_XLEN-1:0]  xdata_t;    // data word
    typedef logic [`MS_ALEN-1:0]  addr_t;     // bus address
    typedef logic [`MS_LANES-1:0] lane_sel_t; // one bit per byte lane
    typedef logic [`MS_REGW-1:0]  reg_idx_t;
    typedef logic [31:0]          inst_t;

    // memory op from execute, loads then stores
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LD,
        MEM_LBU,
        MEM_LHU,
        MEM_LWU,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SD
    } mem_op_e;

    // source of the writeback value
    typedef enum logic [1:0] {
        SEL_ALU,
        SEL_LINK, // pc+4
        SEL_LOAD,
        SEL_CSR
    } wb_sel_e;

    // bus master FSM
    typedef enum logic [1:0] {
        DM_IDLE,
        DM_ACCESS,
        DM_DONE
    } dmem_state_e;

    // ******************************
    // records between stages
    // ******************************
    typedef struct packed {
        xdata_t  pc;
        inst_t   inst;
        mem_op_e mem_op;
        wb_sel_e wb_sel;
        logic    wen;
        xdata_t  alu_out; // effective address for loads/stores
        xdata_t  src2;    // store data, csr read value
    } ex_mem_t;

    typedef struct packed {
        xdata_t   pc;
        inst_t    inst;
        logic     wen;
        reg_idx_t rd;
        xdata_t   wdata;
    } mem_wb_t;

    // register write seen in writeback
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xdata_t   data;
    } reg_wr_t;

endpackage

/* hdl/mem_stage_top.sv */
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  mem_stage_pkg::ex_mem_t   in_item,
    output logic                     in_ready,
    output logic                     out_valid,
    input  logic                     out_ready,
    output mem_stage_pkg::mem_wb_t   out_item,
    input  mem_stage_pkg::reg_wr_t   wb_fwd,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output mem_stage_pkg::addr_t     wb_adr,
    output mem_stage_pkg::lane_sel_t wb_sel,
    output mem_stage_pkg::xdata_t    wb_dat_o,
    input  mem_stage_pkg::xdata_t    wb_dat_i,
    input  logic                     wb_ack
);

    mem_stage_pkg::ex_mem_t   held_item;
    logic                     held_valid;
    mem_stage_pkg::xdata_t    st_data;
    mem_stage_pkg::lane_sel_t st_sel;
    mem_stage_pkg::xdata_t    rdata;
    mem_stage_pkg::xdata_t    ld_value;
    logic                     mem_done;
    logic                     is_mem;
    logic                     is_store;
    logic                     start;
    logic                     leave;

    // ******************************
    // handshake glue
    // ******************************
    assign is_mem   = (held_item.mem_op != mem_stage_pkg::MEM_NONE);
    assign is_store = held_item.mem_op inside {mem_stage_pkg::MEM_SB, mem_stage_pkg::MEM_SH,
                                               mem_stage_pkg::MEM_SW, mem_stage_pkg::MEM_SD};

    assign out_valid = held_valid && (!is_mem || mem_done); // mem items wait for the bus
    assign leave     = out_valid && out_ready;
    assign in_ready  = !held_valid || leave;                // empty, or emptying now

    // master idle means no open cycle and no finished access parked
    assign start = held_valid && is_mem && !wb_cyc && !mem_done;

    ex_mem_reg ex_mem_reg_i (
        .clk        (clk),
        .rst        (rst),
        .load_en    (in_ready),
        .hold_clear (leave),
        .in_item    (in_item),
        .in_valid   (in_valid),
        .held_item  (held_item),
        .held_valid (held_valid)
    );

    store_align store_align_i (
        .held_item (held_item),
        .wb_fwd    (wb_fwd),
        .st_data   (st_data),
        .st_sel    (st_sel)
    );

    load_extract load_extract_i (
        .mem_op   (held_item.mem_op),
        .byte_off (held_item.alu_out[2:0]),
        .rdata    (rdata),
        .ld_value (ld_value)
    );

    dmem_wb_master dmem_wb_master_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .is_store (is_store),
        .addr     (held_item.alu_out[`MS_ALEN-1:0]),
        .st_data  (st_data),
        .st_sel   (st_sel),
        .leave    (leave),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .mem_done (mem_done),
        .rdata    (rdata),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_o (wb_dat_o)
    );

    // ******************************
    // writeback record
    // ******************************
    assign out_item.pc   = held_item.pc;
    assign out_item.inst = held_item.inst;
    assign out_item.wen  = held_item.wen;
    assign out_item.rd   = held_item.inst[11:7];

    always_comb begin
        case (held_item.wb_sel)
            mem_stage_pkg::SEL_LINK: out_item.wdata = held_item.pc + mem_stage_pkg::xdata_t'(4);
            mem_stage_pkg::SEL_LOAD: out_item.wdata = ld_value;
            mem_stage_pkg::SEL_CSR:  out_item.wdata = held_item.src2; // csr old value
            default:                 out_item.wdata = held_item.alu_out;
        endcase
    end

    // record frozen under back-pressure, load data included
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_item));

endmodule

/* hdl/store_align.sv */
`include "mem_stage_settings.svh"

module store_align (
    input  mem_stage_pkg::ex_mem_t   held_item,
    input  mem_stage_pkg::reg_wr_t   wb_fwd,
    output mem_stage_pkg::xdata_t    st_data,
    output mem_stage_pkg::lane_sel_t st_sel
);

    localparam int OFFW = $clog2(`MS_LANES);

    mem_stage_pkg::reg_idx_t  rs2;
    mem_stage_pkg::xdata_t    src;      // store data after forwarding
    mem_stage_pkg::xdata_t    data_lo;  // data in the low lanes
    mem_stage_pkg::lane_sel_t sel_lo;   // select for the low lanes
    logic [OFFW-1:0]          off;
    logic                     fwd_hit;

    assign rs2 = held_item.inst[24:20];
    assign off = held_item.alu_out[OFFW-1:0];

    // x0 never forwards
    assign fwd_hit = wb_fwd.valid && (wb_fwd.rd != '0) && (wb_fwd.rd == rs2);
    assign src     = fwd_hit ? wb_fwd.data : held_item.src2;

    // ******************************
    // access size
    // ******************************
    always_comb begin
        case (held_item.mem_op)
            mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_SB: begin
                data_lo = mem_stage_pkg::xdata_t'(src[7:0]);
                sel_lo  = mem_stage_pkg::lane_sel_t'(8'h01);
            end
            mem_stage_pkg::MEM_LH, mem_stage_pkg::MEM_LHU, mem_stage_pkg::MEM_SH: begin
                data_lo = mem_stage_pkg::xdata_t'(src[15:0]);
                sel_lo  = mem_stage_pkg::lane_sel_t'(8'h03);
            end
            mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LWU, mem_stage_pkg::MEM_SW: begin
                data_lo = mem_stage_pkg::xdata_t'(src[31:0]);
                sel_lo  = mem_stage_pkg::lane_sel_t'(8'h0f);
            end
            default: begin                // double, whole word
                data_lo = src;
                sel_lo  = '1;
            end
        endcase
    end

    // move into the addressed lanes, alignment is up to execute
    assign st_data = data_lo << {off, 3'b000};
    assign st_sel  = sel_lo << off;

endmodule

/* include/mem_stage_settings.svh */
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// ******************************
// memory stage widths
// ******************************

// integer register / data bus width, rv64
`define MS_XLEN 64

// address width driven onto the wishbone bus
`define MS_ALEN 32

// bytes per data word, one select bit each
`define MS_LANES 8

// register index, x0..x31
`define MS_REGW 5

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_mem_stage \
    -Mdir obj_dir -o tb_mem_stage_sim

./obj_dir/tb_mem_stage_sim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/tb_dmem_model.sv */
module tb_dmem_model #(
    parameter logic [31:0] SEED = 32'h75f113e5
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  mem_stage_pkg::addr_t     adr,
    input  mem_stage_pkg::lane_sel_t sel,
    input  mem_stage_pkg::xdata_t    dat_i,
    output mem_stage_pkg::xdata_t    dat_o,
    output logic                     ack
);

    localparam int DEPTH = 16;

    mem_stage_pkg::xdata_t mem [DEPTH]; // shadow array, read by the testbench
    logic [31:0]           rng;
    logic [3:0]            idx;
    int                    wait_left;  // wait states before the next ack

    assign idx = adr[6:3];              // 8-byte words, 128 bytes total

    function automatic logic [31:0] step_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // every word differs, built from its whole index
    function automatic mem_stage_pkg::xdata_t fill_word(int a);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = 32'(a) * 32'h9e3779b9;
        lo = ~(32'(a) * 32'h85ebca6b);
        return {hi ^ 32'h5a5a0000, lo};
    endfunction

    initial begin
        rng = SEED;
        ack = 1'b0;                         // bus quiet before the first edge
        dat_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(i);
        end
    end

    // ******************************
    // classic slave, one beat per cycle
    // ******************************
    always @(posedge clk) begin
        if (rst) begin
            ack       <= 1'b0;
            wait_left <= 0;
        end else if (ack) begin
            ack       <= 1'b0;               // master drops stb now
            wait_left <= int'(step_rand() & 32'd3);
        end else if (cyc && stb) begin
            if (wait_left > 0) begin
                wait_left <= wait_left - 1;  // stall the master
            end else begin
                ack <= 1'b1;
                if (we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (sel[b]) mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
                    end
                end else begin
                    dat_o <= mem[idx];
                end
            end
        end
    end

endmodule

/* verif/tb_mem_stage.sv */
module tb_mem_stage;

    localparam int DEPTH = 16;
    localparam int LIMIT = 200;           // cycles per wait

    // prediction for one item in the stage
    typedef struct packed {
        mem_stage_pkg::mem_wb_t   rec;
        logic                     is_mem;
        logic                     is_store;
        mem_stage_pkg::addr_t     adr;
        mem_stage_pkg::lane_sel_t sel;
        mem_stage_pkg::xdata_t    dat;
    } expect_t;

    logic clk, rst, in_valid, in_ready, out_valid, out_ready;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    mem_stage_pkg::ex_mem_t   in_item;
    mem_stage_pkg::mem_wb_t   out_item;
    mem_stage_pkg::reg_wr_t   wb_fwd;
    mem_stage_pkg::addr_t     wb_adr;
    mem_stage_pkg::lane_sel_t wb_sel;
    mem_stage_pkg::xdata_t    wb_dat_o, wb_dat_i;

    mem_stage_pkg::xdata_t  ref_mem [DEPTH];   // expected memory contents
    expect_t                exp_q[$];
    expect_t                exp_head;
    logic                   head_ok, take, give, stall_on, ready_next, timed_out;
    mem_stage_pkg::ex_mem_t give_item;
    mem_stage_pkg::reg_wr_t give_fwd;
    logic [31:0]            rng_state, stall_r;
    int                     stall_left, errors, n_out, mark;
    string                  why;

    mem_stage_top dut_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_item(in_item), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .out_item(out_item), .wb_fwd(wb_fwd),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_sel(wb_sel),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    tb_dmem_model dmem_i (
        .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .sel(wb_sel), .dat_i(wb_dat_o), .dat_o(wb_dat_i), .ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int op_bytes(mem_stage_pkg::mem_op_e op);
        case (op)
            mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_SB: return 1;
            mem_stage_pkg::MEM_LH, mem_stage_pkg::MEM_LHU, mem_stage_pkg::MEM_SH: return 2;
            mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LWU, mem_stage_pkg::MEM_SW: return 4;
            default: return 8;
        endcase
    endfunction

    // ******************************
    // reference prediction
    // ******************************
    function automatic expect_t predict(mem_stage_pkg::ex_mem_t it, mem_stage_pkg::reg_wr_t fwd);
        expect_t               e;
        mem_stage_pkg::xdata_t src, val;
        int                    n, off, idx;
        e = '0;
        val = '0;
        n = op_bytes(it.mem_op);
        off = int'(it.alu_out[2:0]);
        idx = int'(it.alu_out[6:3]);
        e.rec.pc = it.pc;
        e.rec.inst = it.inst;
        e.rec.wen = it.wen;
        e.rec.rd = it.inst[11:7];
        e.is_mem = (it.mem_op != mem_stage_pkg::MEM_NONE);
        e.is_store = (it.mem_op >= mem_stage_pkg::MEM_SB);
        e.adr = {it.alu_out[31:3], 3'b000};
        if (e.is_store) begin
            src = it.src2;
            if (fwd.valid && fwd.rd != 5'd0 && fwd.rd == it.inst[24:20]) src = fwd.data;
            for (int b = 0; b < n; b++) begin
                e.dat[(off+b)*8 +: 8] = src[b*8 +: 8];
                e.sel[off+b] = 1'b1;
                ref_mem[idx][(off+b)*8 +: 8] = src[b*8 +: 8]; // only the stored bytes
            end
        end else if (e.is_mem) begin
            for (int b = 0; b < n; b++) val[b*8 +: 8] = ref_mem[idx][(off+b)*8 +: 8];
            if (it.mem_op inside {mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LH,
                                  mem_stage_pkg::MEM_LW} && val[n*8-1]) begin
                for (int i = n * 8; i < 64; i++) val[i] = 1'b1;   // sign fill
            end
        end
        case (it.wb_sel)
            mem_stage_pkg::SEL_LINK: e.rec.wdata = it.pc + 64'd4;
            mem_stage_pkg::SEL_LOAD: e.rec.wdata = val;
            mem_stage_pkg::SEL_CSR:  e.rec.wdata = it.src2;
            default:                 e.rec.wdata = it.alu_out;
        endcase
        return e;
    endfunction

    function automatic mem_stage_pkg::ex_mem_t make_item(mem_stage_pkg::mem_op_e op,
                                                          mem_stage_pkg::wb_sel_e sel);
        mem_stage_pkg::ex_mem_t it;
        logic [31:0]            r;
        r = next_rand();
        it.pc = {32'h0, r & 32'hffff_fffc};
        it.inst = next_rand();
        it.mem_op = op;
        it.wb_sel = sel;
        it.wen = r[7];
        it.alu_out = {next_rand(), next_rand()};
        if (op != mem_stage_pkg::MEM_NONE) begin   // naturally aligned, inside the model
            it.alu_out = 64'(r[6:0]) & ~64'(op_bytes(op) - 1);
        end
        it.src2 = {next_rand(), next_rand()};
        return it;
    endfunction

    // handshake seen at negedge, queue moved at the next posedge
    always @(negedge clk) begin
        take = out_valid && out_ready && !rst;
        give = in_valid && in_ready && !rst;
        give_item = in_item;
        give_fwd = wb_fwd;
    end

    always @(posedge clk) begin
        if (take && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            n_out++;
        end
        if (give) exp_q.push_back(predict(give_item, give_fwd));
        head_ok = (exp_q.size() > 0);
        exp_head = head_ok ? exp_q[0] : '0;
    end

    // random out_ready spans, picked at negedge
    always @(negedge clk) begin
        if (!stall_on) begin
            ready_next = 1'b1;
        end else if (stall_left > 0) begin
            ready_next = 1'b0;
            stall_left--;
        end else begin
            stall_r = next_rand();
            ready_next = (stall_r[1:0] != 2'd0);
            if (!ready_next) stall_left = int'(stall_r[4:2]);
        end
    end

    always @(posedge clk) begin
        #1;
        out_ready = ready_next;
    end

    // ******************************
    // checks
    // ******************************
    assert property (@(negedge clk) disable iff (rst)
        out_valid && out_ready |-> head_ok && out_item == exp_head.rec)
        else begin
            errors++;
            $display("Error: out_item got %h expected %h", out_item, exp_head.rec);
        end

    assert property (@(negedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_item))
        else begin
            errors++;
            $display("out_item changed while the stage was stalled");
        end

    assert property (@(negedge clk) disable iff (rst) out_valid && !out_ready |-> !in_ready)
        else begin
            errors++;
            $display("in_ready high while the stage was full and stalled");
        end

    assert property (@(negedge clk) disable iff (rst) wb_cyc |-> exp_head.is_mem)
        else begin
            errors++;
            $display("bus cycle started for an item without a memory op");
        end

    assert property (@(negedge clk) disable iff (rst)
        wb_stb |-> wb_adr == exp_head.adr && wb_we == exp_head.is_store)
        else begin
            errors++;
            $display("Error: wb_adr/wb_we got %h/%h expected %h/%h",
                     wb_adr, wb_we, exp_head.adr, exp_head.is_store);
        end

    assert property (@(negedge clk) disable iff (rst)
        wb_stb && wb_we |-> wb_sel == exp_head.sel && wb_dat_o == exp_head.dat)
        else begin
            errors++;
            $display("Error: wb_sel/wb_dat_o got %h/%h expected %h/%h",
                     wb_sel, wb_dat_o, exp_head.sel, exp_head.dat);
        end

    // a wait that ran out ends the run
    initial begin
        wait (timed_out === 1'b1);
        $display("Timeout: %s", why);
        $display("Done: errors found");
        $finish;
    end

    task automatic abort(string msg);
        why = msg;
        timed_out = 1'b1;
        wait (timed_out === 1'b0);            // caller parks until the run stops
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (exp_q.size() != 0) abort("item never left the stage");
    endtask

    task automatic send(mem_stage_pkg::ex_mem_t it, mem_stage_pkg::reg_wr_t fwd);
        int   cnt;
        logic got;
        cnt = 0;
        got = 1'b0;
        in_item = it;
        wb_fwd = fwd;
        in_valid = 1'b1;
        while (!got && cnt < LIMIT) begin
            @(negedge clk);
            got = in_ready;                   // taken on the coming edge
            @(posedge clk);
            #1;
            cnt++;
        end
        in_valid = 1'b0;
        if (!got) abort("item was not accepted by the stage");
        if (it.mem_op != mem_stage_pkg::MEM_NONE) drain(); // wb_fwd held over the access
    endtask

    task automatic report_test(string name);
        drain();
        $display("test %s: %0d errors", name, errors - mark);
        mark = errors;
    endtask

    function automatic mem_stage_pkg::mem_op_e load_of(mem_stage_pkg::mem_op_e op);
        case (op)
            mem_stage_pkg::MEM_SB: return mem_stage_pkg::MEM_LBU;
            mem_stage_pkg::MEM_SH: return mem_stage_pkg::MEM_LHU;
            mem_stage_pkg::MEM_SW: return mem_stage_pkg::MEM_LWU;
            default: return mem_stage_pkg::MEM_LD;
        endcase
    endfunction

    initial begin
        mem_stage_pkg::ex_mem_t   it;
        mem_stage_pkg::reg_wr_t   fwd;
        mem_stage_pkg::reg_idx_t  rs2;
        mem_stage_pkg::mem_op_e   op;
        mem_stage_pkg::wb_sel_e   sel;
        logic [31:0]              r;
        rng_state = 32'h75f113e5;
        rst = 1'b1;
        in_valid = 1'b0;
        in_item = '0;
        out_ready = 1'b1;
        ready_next = 1'b1;
        wb_fwd = '0;
        stall_on = 1'b0;
        stall_left = 0;
        timed_out = 1'b0;
        errors = 0;
        n_out = 0;
        mark = 0;
        head_ok = 1'b0;
        exp_head = '0;
        take = 1'b0;
        give = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < DEPTH; i++) ref_mem[i] = dmem_i.mem[i];

        // reset state, then the first item goes straight in
        assert (!out_valid && !wb_cyc && !wb_stb)
            else begin
                errors++;
                $display("outputs not idle right after reset");
            end
        send(make_item(mem_stage_pkg::MEM_NONE, mem_stage_pkg::SEL_ALU), '0);
        report_test("reset");

        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            sel = (r[1:0] == 2'd2) ? mem_stage_pkg::SEL_CSR : mem_stage_pkg::wb_sel_e'(r[0]);
            send(make_item(mem_stage_pkg::MEM_NONE, sel), '0);
        end
        report_test("non-memory");

        for (int i = 0; i < 35; i++) begin
            op = mem_stage_pkg::mem_op_e'(4'(1 + i % 7));    // lb .. lwu
            send(make_item(op, mem_stage_pkg::SEL_LOAD), '0);
        end
        report_test("loads");

        for (int i = 0; i < 24; i++) begin
            op = mem_stage_pkg::mem_op_e'(4'(8 + i % 4));    // sb .. sd
            it = make_item(op, mem_stage_pkg::SEL_ALU);
            send(it, '0);
            it.mem_op = load_of(op);                         // read back same place
            it.wb_sel = mem_stage_pkg::SEL_LOAD;
            send(it, '0);
        end
        report_test("stores");

        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            rs2 = mem_stage_pkg::reg_idx_t'(r[4:0] | 5'd1);
            it = make_item(mem_stage_pkg::mem_op_e'(4'(8 + r[6:5])), mem_stage_pkg::SEL_ALU);
            fwd = {1'b1, rs2, next_rand(), next_rand()};
            case (i % 4)
                1: begin                                     // x0 never forwards
                    rs2 = '0;
                    fwd.rd = '0;
                end
                2: fwd.rd = rs2 ^ 5'd3;
                3: fwd.valid = 1'b0;
                default: ;
            endcase
            it.inst[24:20] = rs2;
            send(it, fwd);
        end
        report_test("forwarding");

        stall_on = 1'b1;
        for (int i = 0; i < 48; i++) begin
            r = next_rand();
            op = mem_stage_pkg::mem_op_e'(4'(r % 12));
            sel = mem_stage_pkg::wb_sel_e'(r[9:8]);
            if (op inside {[mem_stage_pkg::MEM_LB:mem_stage_pkg::MEM_LWU]}) begin
                sel = mem_stage_pkg::SEL_LOAD;
            end else if (sel == mem_stage_pkg::SEL_LOAD) begin
                sel = mem_stage_pkg::SEL_ALU;
            end
            send(make_item(op, sel), '0);
        end
        report_test("back-pressure");
        stall_on = 1'b0;

        for (int i = 0; i < DEPTH; i++) begin
            assert (dmem_i.mem[i] == ref_mem[i])
                else begin
                    errors++;
                    $display("Error: mem[%0d] got %h expected %h", i, dmem_i.mem[i], ref_mem[i]);
                end
        end

        $display("tests 6, items checked %0d, errors %0d", n_out, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
